/* ps2_dual_kbd.f */
source/ps2_pkg.sv
source/ps2_frame_rx.sv
source/scan_event_unit.sv
source/ps2_dual_kbd.sv
sim/ps2_frame_gen.sv
sim/ps2_dual_kbd_assert.sv
sim/ps2_dual_kbd_tb.sv

/* sim/ps2_dual_kbd_tb.sv */
//********************
// dual PS/2 keyboard front end testbench
// two keyboard models, reference prefix decoder and event compare
//********************

module ps2_dual_kbd_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [7:0] byte_list_t [$];

    localparam int ready_timeout = 300;         // clk cycles after a frame ends
    localparam int err_timeout   = 1200;        // covers the idle limit

    logic                 clk;
    logic                 rst;
    logic                 rd;
    wire                  kbd0_clk, kbd0_data;
    wire                  kbd1_clk, kbd1_data;
    ps2_pkg::scan_event_t key_event;
    logic                 ready;
    logic [1:0]           overrun;
    logic [1:0]           frame_err;

    ps2_pkg::scan_event_t exp0 [$];             // expected events, port 0
    ps2_pkg::scan_event_t exp1 [$];             // expected events, port 1
    string                test_name;
    int                   mismatch_cnt;
    int                   timeout_cnt;

    ps2_dual_kbd #(.idle_limit(400)) dut0 (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   ({kbd1_clk, kbd0_clk}),
        .ps2_data  ({kbd1_data, kbd0_data}),
        .rd        (rd),
        .key_event (key_event),
        .ready     (ready),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

    ps2_frame_gen kbd0 (.clk(clk), .ps2_clk(kbd0_clk), .ps2_data(kbd0_data));
    ps2_frame_gen kbd1 (.clk(clk), .ps2_clk(kbd1_clk), .ps2_data(kbd1_data));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 100 MHz
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    // set 2 prefix rule, E0 marks extended, F0 marks key up
    function automatic ps2_pkg::scan_event_t expected_event(input logic port,
                                                            input byte_list_t bytes);
        ps2_pkg::scan_event_t ev;
        logic                 ext;
        logic                 brk;
        ev  = '0;
        ext = 1'b0;
        brk = 1'b0;
        foreach (bytes[i]) begin
            if (bytes[i] == 8'hE0) begin
                ext = 1'b1;
            end else if (bytes[i] == 8'hF0) begin
                brk = 1'b1;
            end else begin
                ev = {port, ext, brk, bytes[i]};    // port, extended, released, code
                ext = 1'b0;
                brk = 1'b0;
            end
        end
        return ev;
    endfunction

    function automatic logic [7:0] rand_code();
        logic [7:0] c;
        c = 8'($urandom);
        while (c == 8'hE0 || c == 8'hF0) begin
            c = 8'($urandom);                   // prefixes are not key codes
        end
        return c;
    endfunction

    task automatic send_byte(input logic port, input logic [7:0] code, input logic bad_parity,
                             input logic bad_stop, input int nbits);
        if (port) begin
            kbd1.send_frame(code, bad_parity, bad_stop, nbits);
        end else begin
            kbd0.send_frame(code, bad_parity, bad_stop, nbits);
        end
    endtask

    task automatic wait_drained();
        int cnt;
        cnt = 0;
        while ((exp0.size() + exp1.size() > 0 || rd) && cnt < ready_timeout + 10) begin
            @(negedge clk);
            cnt++;
        end
        if (exp0.size() + exp1.size() > 0 || rd) begin
            $display("timeout: expected events were not all read in test %s", test_name);
            timeout_cnt++;
        end
        @(negedge clk);
    endtask

    task automatic wait_frame_err(input logic port);
        int cnt;
        cnt = 0;
        while (!frame_err[port] && cnt < err_timeout) begin
            @(negedge clk);
            cnt++;
        end
        if (!frame_err[port]) begin
            $display("timeout: frame error flag of port %0d never rose in test %s",
                     port, test_name);
            timeout_cnt++;
        end
    endtask

    // send a byte list, prefixes must not raise ready, then expect one event
    task automatic run_sequence(input string name, input logic port, input byte_list_t bytes);
        ps2_pkg::scan_event_t exp_ev;
        test_name = name;
        exp_ev    = expected_event(port, bytes);
        foreach (bytes[i]) begin
            send_byte(port, bytes[i], 1'b0, 1'b0, 11);
            if (bytes[i] == ps2_pkg::code_ext || bytes[i] == ps2_pkg::code_brk) begin
                check_value({name, " prefix ready"}, 0, ready);
            end
        end
        if (port) begin
            exp1.push_back(exp_ev);
        end else begin
            exp0.push_back(exp_ev);
        end
        wait_drained();
    endtask

    // compare process, port 0 expectations first
    initial begin : compare_proc
        int                   cnt;
        ps2_pkg::scan_event_t exp_ev;
        forever begin
            @(negedge clk);
            if (exp0.size() + exp1.size() > 0) begin
                cnt = 0;
                while (!ready && cnt < ready_timeout) begin
                    @(negedge clk);
                    cnt++;
                end
                if (exp0.size() > 0) begin
                    exp_ev = exp0.pop_front();
                end else begin
                    exp_ev = exp1.pop_front();
                end
                if (!ready) begin
                    $display("timeout: no event became ready in test %s", test_name);
                    timeout_cnt++;
                end else begin
                    check_value(test_name, exp_ev, key_event);
                    rd = 1'b1;                  // one cycle read strobe
                    @(negedge clk);
                    rd = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        byte_list_t seq;
        logic [7:0] a;
        logic [7:0] b;
        int         first_draw;
        rst          = 1'b1;
        rd           = 1'b0;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        test_name    = "reset";
        first_draw   = $urandom(32'hfbb8103f);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset ready", 0, ready);
        check_value("reset overrun", 0, overrun);
        check_value("reset frame_err", 0, frame_err);

        // plain make codes on each port
        for (int n = 0; n < 4; n++) begin
            seq = {rand_code()};
            run_sequence("make code", n[0], seq);
        end

        // prefix sequences
        seq = {8'hF0, rand_code()};
        run_sequence("break code", 1'b0, seq);
        seq = {8'hE0, rand_code()};
        run_sequence("extended code", 1'b1, seq);
        seq = {8'hE0, 8'hF0, rand_code()};
        run_sequence("extended break", 1'b0, seq);
        seq = {8'hE0, 8'hF0, rand_code()};
        run_sequence("extended break", 1'b1, seq);

        // bad parity on port 0, bad stop on port 1
        test_name = "bad parity";
        send_byte(1'b0, rand_code(), 1'b1, 1'b0, 11);
        wait_frame_err(1'b0);
        check_value("bad parity ready", 0, ready);
        seq = {rand_code()};
        run_sequence("after bad parity", 1'b0, seq);
        check_value("frame_err cleared", 0, frame_err);
        test_name = "bad stop";
        send_byte(1'b1, rand_code(), 1'b0, 1'b1, 11);
        wait_frame_err(1'b1);
        check_value("bad stop ready", 0, ready);
        seq = {rand_code()};
        run_sequence("after bad stop", 1'b1, seq);
        check_value("frame_err cleared", 0, frame_err);  // flag must be low before timeout

        // truncated frame, idle timeout
        test_name = "truncated";
        send_byte(1'b1, rand_code(), 1'b0, 1'b0, 5);
        wait_frame_err(1'b1);
        check_value("truncated ready", 0, ready);
        seq = {rand_code()};
        run_sequence("after truncated", 1'b1, seq);

        // overrun, second code replaces the first
        test_name = "overrun";
        a = rand_code();
        b = rand_code();
        send_byte(1'b0, a, 1'b0, 1'b0, 11);
        send_byte(1'b0, b, 1'b0, 1'b0, 11);
        seq = {b};
        check_value("overrun flag", 1, overrun[0]);
        check_value("overrun shown", expected_event(1'b0, seq), key_event);
        exp0.push_back(expected_event(1'b0, seq));
        wait_drained();
        check_value("overrun cleared", 0, overrun[0]);

        // both ports at once
        test_name = "both ports";
        a = rand_code();
        b = rand_code();
        fork
            send_byte(1'b0, a, 1'b0, 1'b0, 11);
            send_byte(1'b1, b, 1'b0, 1'b0, 11);
        join
        seq = {a};
        exp0.push_back(expected_event(1'b0, seq));
        seq = {b};
        exp1.push_back(expected_event(1'b1, seq));
        wait_drained();
        check_value("both ports ready", 0, ready);

        $display("checks done: %0d value errors, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim/ps2_dual_kbd_assert.sv */
//********************
// event unit checks
// reset state, read release, receiver pulses and port order
//********************

module ps2_dual_kbd_assert (
    input logic                 clk,
    input logic                 rst,
    input ps2_pkg::rx_byte_t    rx0,
    input ps2_pkg::rx_byte_t    rx1,
    input logic                 rd,
    input ps2_pkg::scan_event_t key_event,
    input logic                 ready,
    input logic [1:0]           full
);

    timeunit 1ns;
    timeprecision 1ps;

    // nothing shown right after reset
    ready_after_rst: assert property (@(posedge clk) rst |=> !ready)
        else $error("ready high after reset");

    // with both slots full one read leaves an event behind
    ready_keeps: assert property (@(posedge clk) disable iff (rst)
        (rd && full[0] && full[1]) |=> ready)
        else $error("ready dropped with an event still stored");

    ready_fall_rd: assert property (@(posedge clk) disable iff (rst)
        $fell(ready) |-> $past(rd))
        else $error("ready dropped without a read");

    // receiver pulses are exclusive
    rx0_excl: assert property (@(posedge clk) disable iff (rst)
        !(rx0.valid && rx0.frame_err))
        else $error("port 0 valid and frame_err together");

    rx1_excl: assert property (@(posedge clk) disable iff (rst)
        !(rx1.valid && rx1.frame_err))
        else $error("port 1 valid and frame_err together");

    // port 1 only shown when port 0 slot is empty
    port_order: assert property (@(posedge clk) disable iff (rst)
        (ready && key_event.port) |-> !full[0])
        else $error("port 1 event shown ahead of port 0");

endmodule

bind scan_event_unit ps2_dual_kbd_assert evt_checks (
    .clk       (clk),
    .rst       (rst),
    .rx0       (rx0),
    .rx1       (rx1),
    .rd        (rd),
    .key_event (key_event),
    .ready     (ready),
    .full      (full)
);

/* sim/ps2_frame_gen.sv */
//********************
// PS/2 keyboard model
// bit-bangs one 11-bit device frame per call, with bad parity,
// bad stop bit and truncation options
//********************

module ps2_frame_gen #(
    parameter int half_period = 20              // clk cycles per ps2 clock phase
) (
    input  logic clk,
    output logic ps2_clk,                       // open collector line, idle high
    output logic ps2_data
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        ps2_clk  = 1'b1;                        // bus idle
        ps2_data = 1'b1;
    end

    // frame is start, 8 data lsb first, odd parity, stop
    task automatic send_frame(
        input logic [7:0] code,
        input logic       bad_parity,           // flip the parity bit
        input logic       bad_stop,             // send stop as 0
        input int         nbits                 // below 11 truncates the frame
    );
        logic [10:0] bits;
        bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
        @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            ps2_data = bits[i];                 // data moves with the rising edge
            repeat (half_period) @(negedge clk);
            ps2_clk = 1'b0;                     // host samples here
            repeat (half_period) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;                        // release data line
        repeat (half_period) @(negedge clk);    // idle gap
    endtask

endmodule

/* source/ps2_dual_kbd.sv */
//********************
// dual port PS/2 keyboard front end
// two frame receivers feeding one event unit
//********************

module ps2_dual_kbd #(
    parameter int idle_limit = 2000             // in-frame ps2 clock high limit
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           ps2_clk,       // one line per port
    input  logic [1:0]           ps2_data,
    input  logic                 rd,            // cpu read strobe
    output ps2_pkg::scan_event_t key_event,
    output logic                 ready,
    output logic [1:0]           overrun,
    output logic [1:0]           frame_err
);

    ps2_pkg::rx_byte_t rx0;                     // port 0 byte stream
    ps2_pkg::rx_byte_t rx1;                     // port 1 byte stream

    ps2_frame_rx #(
        .idle_limit (idle_limit)
    ) rx_port0 (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk[0]),
        .ps2_data (ps2_data[0]),
        .rx       (rx0)
    );

    ps2_frame_rx #(
        .idle_limit (idle_limit)
    ) rx_port1 (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk[1]),
        .ps2_data (ps2_data[1]),
        .rx       (rx1)
    );

    scan_event_unit evt0 (
        .clk       (clk),
        .rst       (rst),
        .rx0       (rx0),
        .rx1       (rx1),
        .rd        (rd),
        .key_event (key_event),
        .ready     (ready),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

endmodule

/* source/scan_event_unit.sv */
//********************
// scan code event unit
// per port set 2 prefix decoding and one event slot per port,
// port 0 shown first, rd releases the shown event
//********************

module scan_event_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  ps2_pkg::rx_byte_t    rx0,           // port 0 receiver
    input  ps2_pkg::rx_byte_t    rx1,           // port 1 receiver
    input  logic                 rd,            // cpu read strobe
    output ps2_pkg::scan_event_t key_event,     // currently shown event
    output logic                 ready,         // any slot full
    output logic [1:0]           overrun,       // sticky, slot overwritten
    output logic [1:0]           frame_err      // sticky, bad frame seen
);

    ps2_pkg::rx_byte_t      rx         [2];
    ps2_pkg::prefix_state_e pstate     [2];     // prefix state per port
    ps2_pkg::prefix_state_e pstate_nxt [2];
    ps2_pkg::scan_event_t   slot       [2];     // one event per port
    ps2_pkg::scan_event_t   new_evt    [2];
    logic [1:0]             full;               // slot holds an event
    logic [1:0]             is_code;            // non prefix byte this cycle
    logic [1:0]             rd_hit;             // slot released by rd
    logic                   show_port;          // 0 when slot 0 full

    assign rx[0] = rx0;
    assign rx[1] = rx1;

    // event from the pending prefix state
    function automatic ps2_pkg::scan_event_t build_event(
        input logic                   port,
        input ps2_pkg::prefix_state_e st,
        input logic [7:0]             code
    );
        ps2_pkg::scan_event_t ev;
        ev.port     = port;
        ev.extended = (st == ps2_pkg::st_ext) || (st == ps2_pkg::st_ext_brk);
        ev.released = (st == ps2_pkg::st_brk) || (st == ps2_pkg::st_ext_brk);
        ev.code     = code;
        return ev;
    endfunction

    // prefix decoding, same rule on both ports
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            is_code[p]    = 1'b0;
            pstate_nxt[p] = pstate[p];                  // hold by default
            new_evt[p]    = build_event(1'(p), pstate[p], rx[p].code);
            if (rx[p].valid) begin
                case (rx[p].code)
                    ps2_pkg::code_ext: begin
                        pstate_nxt[p] = ps2_pkg::st_ext;
                    end
                    ps2_pkg::code_brk: begin
                        if ((pstate[p] == ps2_pkg::st_ext) ||
                            (pstate[p] == ps2_pkg::st_ext_brk)) begin
                            pstate_nxt[p] = ps2_pkg::st_ext_brk;  // E0 F0 xx
                        end else begin
                            pstate_nxt[p] = ps2_pkg::st_brk;
                        end
                    end
                    default: begin
                        is_code[p]    = 1'b1;               // finished code
                        pstate_nxt[p] = ps2_pkg::st_idle;
                    end
                endcase
            end
        end
    end

    // output choice, port 0 has priority
    assign show_port = ~full[0];
    assign ready     = |full;
    assign key_event = slot[show_port];

    // rd only acts while something is shown
    assign rd_hit[0] = rd & full[0];
    assign rd_hit[1] = rd & ~full[0] & full[1];

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            full      <= '0;
            overrun   <= '0;
            frame_err <= '0;
            pstate    <= '{ps2_pkg::st_idle, ps2_pkg::st_idle};
        end else begin
            for (int p = 0; p < 2; p++) begin
                pstate[p] <= pstate_nxt[p];
                if (is_code[p]) begin
                    full[p] <= 1'b1;                    // write beats a same cycle read
                end else if (rd_hit[p]) begin
                    full[p] <= 1'b0;
                end
                if (is_code[p] && full[p] && !rd_hit[p]) begin
                    overrun[p] <= 1'b1;                 // unread event lost
                end else if (rd_hit[p]) begin
                    overrun[p] <= 1'b0;
                end
                if (rx[p].frame_err) begin
                    frame_err[p] <= 1'b1;               // set wins over rd
                end else if (rd) begin
                    frame_err[p] <= 1'b0;
                end
            end
        end
    end

    // event slots, payload only
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (is_code[p]) begin
                slot[p] <= new_evt[p];
            end
        end
    end

endmodule

/* source/ps2_frame_rx.sv */
//********************
// PS/2 frame receiver
// syncs the ps2 lines, samples on falling ps2 clock and checks
// start, stop and odd parity, with an in-frame idle timeout
//********************

module ps2_frame_rx #(
    parameter int idle_limit = 2000             // clk cycles of high ps2_clk inside a frame
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ps2_clk,           // async line from keyboard
    input  logic              ps2_data,          // async line from keyboard
    output ps2_pkg::rx_byte_t rx
);

    localparam int idle_w = $clog2(idle_limit + 1);

    logic [2:0]        clk_sync;                // 2 sync flops + edge register
    logic [1:0]        data_sync;               // 2 sync flops
    logic              sample;                  // falling edge seen
    logic [3:0]        count;                   // bits taken so far
    logic [10:0]       shift;                   // start, 8 data, parity, stop
    logic              frame_end;               // 11th bit taken last cycle
    logic              frame_ok;
    logic [idle_w-1:0] idle_cnt;                // high time inside a frame
    logic              timeout;
    logic              valid_q;
    logic              err_q;
    logic [7:0]        code_q;

    // line synchronizers, idle level is high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};   // shift in newest level
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign sample = clk_sync[2] & ~clk_sync[1];      // delayed high, newer low

    // bit counter, 0..10
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            frame_end <= 1'b0;
        end else begin
            frame_end <= 1'b0;                       // single cycle
            if (timeout) begin
                count <= '0;                         // abandon partial frame
            end else if (sample) begin
                if (count == 4'd10) begin
                    count     <= '0;                 // stop bit taken
                    frame_end <= 1'b1;
                end else begin
                    count <= count + 4'd1;
                end
            end
        end
    end

    // shift right, so bit 0 ends up holding the start bit
    always_ff @(posedge clk) begin
        if (sample) begin
            shift <= {data_sync[1], shift[10:1]};
        end
    end

    // idle watchdog, counts while ps2 clock stays high mid frame
    assign timeout = (count != 4'd0) && clk_sync[1] &&
                     (idle_cnt == idle_w'(idle_limit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if ((count == 4'd0) || !clk_sync[1] || timeout) begin
            idle_cnt <= '0;                          // line low or no frame open
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = ~shift[0] & shift[10] & (^shift[9:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= frame_end & frame_ok;
            err_q   <= (frame_end & ~frame_ok) | timeout;  // never both, count is 0 at frame_end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            code_q <= shift[8:1];                    // data byte, lsb first on the line
        end
    end

    assign rx.valid     = valid_q;
    assign rx.frame_err = err_q;
    assign rx.code      = code_q;

endmodule

/* source/ps2_pkg.sv */
//********************
// PS/2 keyboard shared types
// receiver byte, key event, prefix states and scan code set 2 prefixes
//********************

package ps2_pkg;

    // scan code set 2 prefix bytes
    localparam logic [7:0] code_ext = 8'hE0;    // extended key prefix
    localparam logic [7:0] code_brk = 8'hF0;    // break (key up) prefix

    // prefix tracking per port
    typedef enum logic [1:0] {
        st_idle    = 2'd0,                      // no prefix pending
        st_ext     = 2'd1,                      // E0 seen
        st_brk     = 2'd2,                      // F0 seen
        st_ext_brk = 2'd3                       // E0 then F0 seen
    } prefix_state_e;

    // one receiver output, 10 bits
    typedef struct packed {
        logic       valid;                      // 1 cycle pulse, good byte
        logic       frame_err;                  // 1 cycle pulse, bad or timed out frame
        logic [7:0] code;                       // received byte
    } rx_byte_t;

    // one decoded key event, 11 bits
    typedef struct packed {
        logic       port;                       // source keyboard port
        logic       extended;                   // E0 prefix seen
        logic       released;                   // F0 prefix seen, key up
        logic [7:0] code;                       // final scan code
    } scan_event_t;

endpackage
